// File: hdl/fpFormatPkg.sv
//////////////////////////////////////////////////
// fpFormatPkg
// single-precision operand format for the divider
// with widths, exponent bias and operand/result structs
//////////////////////////////////////////////////

package fpFormatPkg;

  localparam int MantBits = 23;   // stored fraction bits
  localparam int ExpBits  = 8;
  localparam int ExpBias  = 127;

  // mantissa including the hidden bit
  typedef logic [MantBits:0] mantT;

  // biased exponent as stored
  typedef logic [ExpBits-1:0] expT;

  // exponent before normalization, may leave the biased range
  typedef logic signed [ExpBits+1:0] preExpT;

  // unpacked operand
  typedef struct packed {
    expT  expo;
    mantT mant;
  } fpOperandT;

  // divider result before normalization
  typedef struct packed {
    mantT   mant;
    preExpT expo;
  } divResultT;

endpackage

// File: hdl/divCtrlPkg.sv
//////////////////////////////////////////////////
// divCtrlPkg
// iteration control types of the mantissa divider
// cell count, remainder and per-cycle step
//////////////////////////////////////////////////

package divCtrlPkg;

  import fpFormatPkg::*;

  //////////////////////////////////////////////////
  // iteration sizing
  //////////////////////////////////////////////////

  // add/subtract cells evaluated per clock
  localparam int CellsPerCycleDef = 4;

  // quotient bits per division, one per cell pass
  localparam int QuotBits = MantBits + 1;

  //////////////////////////////////////////////////
  // datapath types
  //////////////////////////////////////////////////

  // signed partial remainder, one bit above the mantissa
  typedef logic [MantBits+1:0] remT;

  // what one clock of iteration hands on
  typedef struct packed {
    remT                         rem;    // remainder after the last cell
    logic [CellsPerCycleDef-1:0] qBits;  // earliest bit in the msb
  } stepT;

endpackage

// File: hdl/divOperandLatch.sv
//////////////////////////////////////////////////
// divOperandLatch
// holds both mantissas and the result exponent
// from an accepted start until the next one
//////////////////////////////////////////////////

`timescale 1ns/1ps

module divOperandLatch
  import fpFormatPkg::*;
(
  input  logic      Clk_CI,
  input  logic      Rst_RBI,
  input  logic      start,
  input  logic      accept,
  input  fpOperandT num,
  input  fpOperandT den,
  output mantT      numLat,
  output mantT      denLat,
  output preExpT    expo
);

  logic   take;
  preExpT expoNext;

  assign take = start & accept;

  // numExp - denExp + bias in 10 bit signed
  assign expoNext = preExpT'({2'b00, num.expo})
                  - preExpT'({2'b00, den.expo})
                  + preExpT'(ExpBias);

  //////////////////////////////////////////////////
  // operand capture
  //////////////////////////////////////////////////

  always_ff @(posedge Clk_CI)
  begin
    if (take)
    begin
      numLat <= num.mant;
      denLat <= den.mant;
    end
  end

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      expo <= '0;
    end
    else if (take)
    begin
      expo <= expoNext;   // valid from the cycle after start
    end
  end

endmodule

// File: hdl/divSequencer.sv
//////////////////////////////////////////////////
// divSequencer
// start delay, iteration counter and the
// ready/done handshake of the divider
//////////////////////////////////////////////////

`timescale 1ns/1ps

module divSequencer
  import divCtrlPkg::*;
#(
  parameter int CellsPerCycle = CellsPerCycleDef
)
(
  input  logic Clk_CI,
  input  logic Rst_RBI,
  input  logic start,
  output logic load,
  output logic iterate,
  output logic ready,
  output logic done
);

  localparam int IterCount = QuotBits / CellsPerCycle;
  localparam int CntW      = (IterCount > 1) ? $clog2(IterCount) : 1;

  logic [CntW-1:0] iterCnt;
  logic            accepted;
  logic            lastIter;

  assign accepted = start & ready;   // starts while busy are dropped
  assign lastIter = iterate & (iterCnt == CntW'(IterCount - 1));

  //////////////////////////////////////////////////
  // start delay and iteration window
  //////////////////////////////////////////////////

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      load    <= 1'b0;
      iterate <= 1'b0;
    end
    else
    begin
      load <= accepted;   // first iteration cycle
      if (accepted)
        iterate <= 1'b1;
      else if (lastIter)
        iterate <= 1'b0;
    end
  end

  // counts iteration cycles, back to zero after the last
  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
      iterCnt <= '0;
    else if (lastIter)
      iterCnt <= '0;
    else if (iterate)
      iterCnt <= iterCnt + 1'b1;
  end

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      done  <= 1'b0;
      ready <= 1'b1;
    end
    else
    begin
      done <= lastIter;   // single cycle pulse
      if (lastIter)
        ready <= 1'b1;
      else if (accepted)
        ready <= 1'b0;
    end
  end

endmodule

// File: hdl/divIterationStage.sv
//////////////////////////////////////////////////
// divIterationStage
// chain of non-restoring add/subtract cells
// giving CellsPerCycle quotient bits per clock
//////////////////////////////////////////////////

`timescale 1ns/1ps

module divIterationStage
  import fpFormatPkg::*;
  import divCtrlPkg::*;
#(
  parameter int CellsPerCycle = CellsPerCycleDef
)
(
  input  logic load,
  input  mantT numLat,
  input  mantT denLat,
  input  stepT stepIn,
  output stepT stepOut
);

  localparam int RemW = $bits(remT);

  remT                         denPos;
  remT                         denNeg;   // ones complement
  remT                         cellA   [CellsPerCycle];
  remT                         cellB   [CellsPerCycle];
  remT                         cellSum [CellsPerCycle];
  logic [CellsPerCycle-1:0]    cellSub;
  logic [CellsPerCycle-1:0]    cellCarry;
  logic [CellsPerCycleDef-1:0] qBits;

  assign denPos = {1'b0, denLat};
  assign denNeg = ~denPos;

  // under load the numerator enters unshifted and is reduced by den
  assign cellA[0]   = load ? {1'b0, numLat} : {stepIn.rem[RemW-2:0], 1'b0};
  assign cellSub[0] = load | stepIn.qBits[0];

  for (genvar k = 0; k < CellsPerCycle; k++)
  begin : gCell
    if (k > 0)
    begin : gChain
      assign cellA[k]   = {cellSum[k-1][RemW-2:0], 1'b0};
      assign cellSub[k] = cellCarry[k-1];   // last bit picks add or sub
    end
    assign cellB[k] = cellSub[k] ? denNeg : denPos;
    // carry out is set when the new remainder is not negative
    assign {cellCarry[k], cellSum[k]} = {1'b0, cellA[k]} + {1'b0, cellB[k]}
                                      + (RemW+1)'(cellSub[k]);
  end

  always_comb
  begin
    qBits = '0;
    for (int k = 0; k < CellsPerCycle; k++)
      qBits[CellsPerCycle-1-k] = cellCarry[k];
  end

  assign stepOut = '{rem: cellSum[CellsPerCycle-1], qBits: qBits};

endmodule

// File: hdl/divQuotientAcc.sv
//////////////////////////////////////////////////
// divQuotientAcc
// partial remainder and quotient registers with
// the final quotient correction
//////////////////////////////////////////////////

`timescale 1ns/1ps

module divQuotientAcc
  import fpFormatPkg::*;
  import divCtrlPkg::*;
#(
  parameter int CellsPerCycle = CellsPerCycleDef
)
(
  input  logic Clk_CI,
  input  logic Rst_RBI,
  input  logic iterate,
  input  stepT stepNext,
  output stepT stepCur,
  output mantT mant
);

  localparam int RemW = $bits(remT);

  remT                 remReg;
  logic [QuotBits-1:0] quotReg;
  logic                remNeg;

  //////////////////////////////////////////////////
  // iteration state
  //////////////////////////////////////////////////

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      remReg  <= '1;
      quotReg <= '0;
    end
    else if (iterate)
    begin
      remReg  <= stepNext.rem;
      // new bits come in at the bottom
      quotReg <= {quotReg[QuotBits-CellsPerCycle-1:0],
                  stepNext.qBits[CellsPerCycle-1:0]};
    end
  end

  // stage needs the remainder and the latest quotient bit
  assign stepCur = '{rem: remReg, qBits: quotReg[CellsPerCycleDef-1:0]};

  //////////////////////////////////////////////////
  // final correction
  //////////////////////////////////////////////////

  assign remNeg = remReg[RemW-1];

  // digits to binary with lsb forced high
  // then one less when the final remainder is negative
  assign mant = {quotReg[QuotBits-1:1], 1'b1} - mantT'(remNeg);

endmodule

// File: hdl/fpDivTop.sv
//////////////////////////////////////////////////
// fpDivTop
// mantissa/exponent divider before normalization
// non-restoring with several cells per clock
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fpDivTop
  import fpFormatPkg::*;
  import divCtrlPkg::*;
#(
  parameter int CellsPerCycle = CellsPerCycleDef
)
(
  input  logic      Clk_CI,
  input  logic      Rst_RBI,
  input  logic      start,
  input  fpOperandT num,
  input  fpOperandT den,
  output logic      ready,
  output logic      done,
  output divResultT result
);

  mantT   numLat;
  mantT   denLat;
  mantT   mantRes;
  preExpT expoRes;
  logic   load;
  logic   iterate;
  stepT   stepCur;
  stepT   stepNext;

  //////////////////////////////////////////////////
  // operands and control
  //////////////////////////////////////////////////

  divOperandLatch iLatch (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .start   (start),
    .accept  (ready),
    .num     (num),
    .den     (den),
    .numLat  (numLat),
    .denLat  (denLat),
    .expo    (expoRes)
  );

  divSequencer #(
    .CellsPerCycle (CellsPerCycle)
  ) iSeq (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .start   (start),
    .load    (load),
    .iterate (iterate),
    .ready   (ready),
    .done    (done)
  );

  //////////////////////////////////////////////////
  // mantissa iteration loop
  //////////////////////////////////////////////////

  divIterationStage #(
    .CellsPerCycle (CellsPerCycle)
  ) iStage (
    .load    (load),
    .numLat  (numLat),
    .denLat  (denLat),
    .stepIn  (stepCur),
    .stepOut (stepNext)
  );

  divQuotientAcc #(
    .CellsPerCycle (CellsPerCycle)
  ) iAcc (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .iterate  (iterate),
    .stepNext (stepNext),
    .stepCur  (stepCur),
    .mant     (mantRes)
  );

  assign result = '{mant: mantRes, expo: expoRes};

endmodule

// File: tests/fpDiv_assert.sv
//////////////////////////////////////////////////
// fpDiv_assert
// handshake properties of the divider top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fpDiv_assert
(
  input logic Clk_CI,
  input logic Rst_RBI,
  input logic start,
  input logic ready,
  input logic done
);

  int failCnt = 0;   // failed assertions so far

  // done is a single cycle pulse
  doneOnePulse: assert property (@(posedge Clk_CI) disable iff (~Rst_RBI)
    done |=> ~done)
    else
    begin
      failCnt = failCnt + 1;
      $error("done stayed high for two cycles");
    end

  // ready comes back exactly when done fires
  readyRiseAtDone: assert property (@(posedge Clk_CI) disable iff (~Rst_RBI)
    $rose(ready) == done)
    else
    begin
      failCnt = failCnt + 1;
      $error("ready rise and done pulse out of step");
    end

  // an accepted start makes the divider busy
  startTakes: assert property (@(posedge Clk_CI) disable iff (~Rst_RBI)
    (ready && start) |=> ~ready)
    else
    begin
      failCnt = failCnt + 1;
      $error("start accepted but ready stayed");
    end

  // idle without start stays idle and quiet
  idleQuiet: assert property (@(posedge Clk_CI) disable iff (~Rst_RBI)
    (ready && ~start) |=> (ready && ~done))
    else
    begin
      failCnt = failCnt + 1;
      $error("activity while idle without start");
    end

endmodule

bind fpDivTop fpDiv_assert hsChecks (
  .Clk_CI  (Clk_CI),
  .Rst_RBI (Rst_RBI),
  .start   (start),
  .ready   (ready),
  .done    (done)
);

// File: tests/fpDivTb.sv
//////////////////////////////////////////////////
// fpDivTb
// reads division vectors, drives fpDivTop and checks
// done timing, mantissa and exponent of every result
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fpDivTb
  import fpFormatPkg::*;
  import divCtrlPkg::*;
();

  localparam int ClkHalf     = 2;   // 4 ns period
  localparam int DriveDelay  = 1;
  localparam int ResetCycles = 16;
  localparam int DoneCycle   = 24 / CellsPerCycleDef + 1;
  localparam int WatchPerVec = 12;
  localparam int WatchSlack  = 40;
  localparam     VecFile     = "tests/fpDivTests.txt";

  logic      Clk_CI;
  logic      Rst_RBI;
  logic      start;
  fpOperandT num;
  fpOperandT den;
  logic      ready;
  logic      done;
  divResultT result;

  string     vecName [$];
  fpOperandT vecNum  [$];
  fpOperandT vecDen  [$];
  mantT      vecMant [$];
  preExpT    vecExpo [$];
  int        vecCount;
  logic      loaded;

  fpDivTop #(
    .CellsPerCycle (CellsPerCycleDef)
  ) UUT (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .start   (start),
    .num     (num),
    .den     (den),
    .ready   (ready),
    .done    (done),
    .result  (result)
  );

  always #ClkHalf Clk_CI = ~Clk_CI;

  //////////////////////////////////////////////////
  // reporting and compare
  //////////////////////////////////////////////////

  task automatic stopWithFail(string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkMant(string name, mantT expV, mantT actV);
    if (actV !== expV)
      stopWithFail($sformatf("Mismatch in %s mant: expected %h, actual %h", name, expV, actV));
  endtask

  task automatic checkExpo(string name, preExpT expV, preExpT actV);
    if (actV !== expV)
      stopWithFail($sformatf("Mismatch in %s expo: expected %h, actual %h", name, expV, actV));
  endtask

  task automatic expectLevel(string name, string what, logic expV, logic actV);
    if (actV !== expV)
      stopWithFail($sformatf("Mismatch in %s %s: expected %b, actual %b",
                             name, what, expV, actV));
  endtask

  task automatic checkCycle(string name, int expV, int actV);
    if (actV != expV)
      stopWithFail($sformatf("Mismatch in %s done cycle: expected %0d, actual %0d",
                             name, expV, actV));
  endtask

  //////////////////////////////////////////////////
  // vectors and driving
  //////////////////////////////////////////////////

  task automatic loadVectors();
    int         fd;
    int         nRead;
    string      line;
    string      name;
    expT        numExp;
    expT        denExp;
    mantT       numMant;
    mantT       denMant;
    mantT       expMant;
    preExpT     expExpo;
    fd = $fopen(VecFile, "r");
    if (fd == 0)
      stopWithFail("could not open the vector file tests/fpDivTests.txt");
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#")   // skip comments and blank lines
      begin
        nRead = $sscanf(line, "%s %h %h %h %h %h %h", name, numExp, numMant,
                        denExp, denMant, expMant, expExpo);
        if (nRead != 7)
          stopWithFail($sformatf("vector line could not be read: %s", line));
        vecName.push_back(name);
        vecNum.push_back(fpOperandT'{expo: numExp, mant: numMant});
        vecDen.push_back(fpOperandT'{expo: denExp, mant: denMant});
        vecMant.push_back(expMant);
        vecExpo.push_back(expExpo);
      end
    end
    $fclose(fd);
    vecCount = vecName.size();
  endtask

  // one division from start to done with an optional start while busy
  task automatic runDivision(int idx, bit interfere);
    int cyc;
    expectLevel(vecName[idx], "ready before start", 1'b1, ready);
    num   = vecNum[idx];
    den   = vecDen[idx];
    start = 1'b1;
    @(posedge Clk_CI);   // start edge
    #DriveDelay;
    start = 1'b0;
    cyc   = 1;
    while (done !== 1'b1 && cyc <= DoneCycle)
    begin
      expectLevel(vecName[idx], "ready while busy", 1'b0, ready);
      if (interfere && cyc == 2)
      begin
        num   = '{expo: 8'h11, mant: 24'hFFFFFF};   // must not be taken
        den   = '{expo: 8'hEE, mant: 24'h800000};
        start = 1'b1;
      end
      else if (cyc == 6)
        start = 1'b0;   // held over cycles 2 to 5
      @(posedge Clk_CI);
      #DriveDelay;
      cyc++;
    end
    if (done !== 1'b1)
      stopWithFail($sformatf("done did not come for %s within %0d cycles of start",
                             vecName[idx], DoneCycle));
    checkCycle(vecName[idx], DoneCycle, cyc);
    expectLevel(vecName[idx], "ready at done", 1'b1, ready);
    checkMant(vecName[idx], vecMant[idx], result.mant);
    checkExpo(vecName[idx], vecExpo[idx], result.expo);
  endtask

  // result must stay put until the next start
  task automatic holdResult(int idx, int idleCycles);
    repeat (idleCycles + 1)
    begin
      @(posedge Clk_CI);
      #DriveDelay;
      expectLevel(vecName[idx], "done after pulse", 1'b0, done);
      checkMant(vecName[idx], vecMant[idx], result.mant);
      checkExpo(vecName[idx], vecExpo[idx], result.expo);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    int i;
    Clk_CI   = 1'b0;
    Rst_RBI  = 1'b0;
    start    = 1'b0;
    num      = '0;
    den      = '0;
    loaded   = 1'b0;
    vecCount = 0;
    loadVectors();
    if (vecCount == 0)
      stopWithFail("the vector file holds no division vectors");
    loaded = 1'b1;
    repeat (ResetCycles) @(posedge Clk_CI);
    #DriveDelay;
    Rst_RBI = 1'b1;
    @(posedge Clk_CI);
    #DriveDelay;
    expectLevel("afterReset", "ready", 1'b1, ready);
    expectLevel("afterReset", "done", 1'b0, done);
    checkMant("afterReset", '0, result.mant);
    checkExpo("afterReset", '0, result.expo);
    for (i = 0; i < vecCount; i++)
    begin
      runDivision(i, (i % 3) == 1);
      holdResult(i, ((i % 4) == 3) ? 2 : 0);   // mostly back to back
    end
    if (UUT.hsChecks.failCnt != 0)
      stopWithFail($sformatf("%0d handshake assertion failures", UUT.hsChecks.failCnt));
    else
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

  // a handshake assertion failure ends the run at once
  always @(UUT.hsChecks.failCnt)
    if (UUT.hsChecks.failCnt != 0)
      stopWithFail("a handshake assertion failed");

  initial
  begin
    wait (loaded === 1'b1);
    repeat (ResetCycles + vecCount * WatchPerVec + WatchSlack) @(posedge Clk_CI);
    stopWithFail("timeout, the divider run did not finish in time");
  end

endmodule

// File: fpDivTop.f
hdl/fpFormatPkg.sv
hdl/divCtrlPkg.sv
hdl/divOperandLatch.sv
hdl/divSequencer.sv
hdl/divIterationStage.sv
hdl/divQuotientAcc.sv
hdl/fpDivTop.sv
tests/fpDiv_assert.sv
tests/fpDivTb.sv

// File: runSim.sh
#!/bin/sh
# builds the divider testbench with Verilator and runs it
# the run counts as passed only if the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
  --top-module fpDivTb \
  -f fpDivTop.f \
  -o fpDivSim \
  && ./obj_dir/fpDivSim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
  && echo "runSim: divider run passed" \
  || { echo "runSim: divider run failed"; exit 1; }

// File: tests/fpDivTests.txt
# name numExp numMant denExp denMant expMant expExpo, all hex
# expMant = floor(numMant * 2^23 / denMant), expExpo = numExp - denExp + 127 as 10 bit signed
equalOne     7F 800000 7F 800000 800000 07F
equalMid     80 C00000 7F C00000 800000 080
equalMax     FE FFFFFF 01 FFFFFF 800000 17C
maxByMin     85 FFFFFF 7C 800000 FFFFFF 088
minByMax     01 800000 FE FFFFFF 400000 382
unitDenA     90 A5A5A5 10 800000 A5A5A5 0FF
unitDenB     10 923456 90 800000 923456 3FF
threeQuarter 7F 900000 7F C00000 600000 07F
twoThird     00 800000 FF C00000 555555 380
fiveFourth   7F F00000 7F C00000 A00000 07F
threeHalf    FF F00000 00 A00000 C00000 17E
fourFifth    3C 800000 C8 A00000 666666 3F3
sixFifth     20 C00000 9F A00000 999999 000
quarterSeven 80 A80000 80 E00000 600000 07F
fourSeventh  7F 800000 7F E00000 492492 07F
maxByOneHalf 82 FFFFFF 7D C00000 AAAAAA 084
ulpAbove     7F 800001 7F 800000 800001 07F
ulpBelow     7F 800000 7F 800001 7FFFFF 07F
sevenFifth   64 E00000 96 A00000 B33333 04D
nineFourteen 96 900000 64 E00000 524924 0B1
unitDenC     A0 C00000 40 800000 C00000 0DF
expHigh      D0 800000 20 800000 800000 12F
